/* common/dial_pkg.sv */
package dial_pkg;

    // rotation direction as decoded from the line prefix
    typedef enum logic [0:0] {
        DIR_LEFT  = 1'b0,
        DIR_RIGHT = 1'b1
    } dir_t;

    // line parser states
    typedef enum logic [1:0] {
        PARSE_DIR  = 2'd0,
        PARSE_NUM  = 2'd1,
        PARSE_SKIP = 2'd2
    } parse_state_t;

    // input characters
    localparam logic [7:0] ASCII_R  = 8'h52;
    localparam logic [7:0] ASCII_L  = 8'h4c;
    localparam logic [7:0] ASCII_NL = 8'h0a;
    localparam logic [7:0] ASCII_0  = 8'h30;
    localparam logic [7:0] ASCII_9  = 8'h39;

    // dial position after reset
    localparam int DIAL_START = 50;

    // cycles from divider input strobe to output strobe
    localparam int DIV_LATENCY = 3;

endpackage

/* dial/div_by_const.sv */
`timescale 1ns/1ps

module div_by_const #(
    parameter int ARG_WIDTH = 11,
    parameter int DIVISOR   = 100
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 input_valid,
    input  logic [ARG_WIDTH-1:0] argument,
    output logic                 outputs_valid,
    output logic [ARG_WIDTH-1:0] quotient,
    output logic [ARG_WIDTH-1:0] remainder
);
    import dial_pkg::*;

    // reciprocal rounded down, so the estimate is exact or one low
    localparam int SHIFT     = ARG_WIDTH + 1;
    localparam int RECIP     = (1 << SHIFT) / DIVISOR;
    localparam int PROD_BITS = ARG_WIDTH + SHIFT + 1;

    logic [DIV_LATENCY-1:0] valid_pipe;

    logic [ARG_WIDTH-1:0] s1_arg;
    logic [PROD_BITS-1:0] s1_product;
    logic [ARG_WIDTH-1:0] s2_arg;
    logic [ARG_WIDTH-1:0] s2_quot;
    logic [ARG_WIDTH-1:0] partial;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[DIV_LATENCY-2:0], input_valid};
        end
    end

    // stage 1: scale by the reciprocal
    always_ff @(posedge clk) begin
        s1_arg     <= argument;
        s1_product <= PROD_BITS'(argument) * PROD_BITS'(RECIP);
    end

    // stage 2: quotient estimate
    always_ff @(posedge clk) begin
        s2_arg  <= s1_arg;
        s2_quot <= ARG_WIDTH'(s1_product >> SHIFT);
    end

    // remainder of the estimate lies in [0, 2*DIVISOR)
    assign partial = s2_arg - ARG_WIDTH'(s2_quot * DIVISOR);

    // stage 3: fix up an estimate that came out one low
    always_ff @(posedge clk) begin
        if (partial >= ARG_WIDTH'(DIVISOR)) begin
            quotient  <= s2_quot + 1'b1;
            remainder <= partial - ARG_WIDTH'(DIVISOR);
        end else begin
            quotient  <= s2_quot;
            remainder <= partial;
        end
    end

    assign outputs_valid = valid_pipe[DIV_LATENCY-1];

endmodule

/* dial/dial_tracker.sv */
`timescale 1ns/1ps

module dial_tracker #(
    parameter int CLICK_BITS  = 10,
    parameter int DIAL_CLICKS = 100
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  click_valid,
    input  dial_pkg::dir_t        click_dir,
    input  logic [CLICK_BITS-1:0] click_count,
    output logic                  zero_crossings_valid,
    output logic [CLICK_BITS-1:0] zero_crossings_count
);
    import dial_pkg::*;

    // one extra bit so dial plus count never wraps
    localparam int CLICK_CNT_BITS = CLICK_BITS + 1;
    localparam int MAX_CLICKS     = (1 << CLICK_BITS) - 1;
    // keeps bias + dial - count positive without changing the residue
    localparam int POSITIVE_BIAS  = (1 + MAX_CLICKS / DIAL_CLICKS) * DIAL_CLICKS;

    typedef logic [CLICK_CNT_BITS-1:0] click_cnt_t;

    click_cnt_t dial;
    click_cnt_t dial_offset;
    click_cnt_t offset_rem;

    logic       cw_arg_valid;
    logic       ccw_arg_valid;
    click_cnt_t cw_arg;
    click_cnt_t ccw_dial_arg;
    click_cnt_t ccw_cross_arg;
    dir_t       arg_dir;
    dir_t       dir_pipe [DIV_LATENCY];

    logic       cw_div_valid;
    click_cnt_t cw_quot;
    click_cnt_t cw_rem;
    logic       ccw_div_valid;
    click_cnt_t ccw_dial_rem;
    click_cnt_t ccw_cross_quot;

    logic       res_valid;
    logic       res_right;

    // offset to zero going left, recomputed every cycle
    always_ff @(posedge clk) begin
        dial_offset <= click_cnt_t'(DIAL_CLICKS) - dial;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cw_arg_valid  <= 1'b0;
            ccw_arg_valid <= 1'b0;
        end else begin
            cw_arg_valid  <= click_valid && (click_dir == DIR_RIGHT);
            ccw_arg_valid <= click_valid && (click_dir == DIR_LEFT);
        end
    end

    always_ff @(posedge clk) begin
        if (click_valid) begin
            arg_dir       <= click_dir;
            cw_arg        <= dial + click_cnt_t'(click_count);
            ccw_dial_arg  <= click_cnt_t'(POSITIVE_BIAS) + dial - click_cnt_t'(click_count);
            // offset_rem was settled well before this click arrived
            ccw_cross_arg <= offset_rem + click_cnt_t'(click_count);
        end
    end

    // remember which path the result in the dividers belongs to
    always_ff @(posedge clk) begin
        dir_pipe[0] <= arg_dir;
        for (int i = 1; i < DIV_LATENCY; i++) begin
            dir_pipe[i] <= dir_pipe[i-1];
        end
    end

    div_by_const #(
        .ARG_WIDTH (CLICK_CNT_BITS),
        .DIVISOR   (DIAL_CLICKS)
    ) cw_div_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .input_valid   (cw_arg_valid),
        .argument      (cw_arg),
        .outputs_valid (cw_div_valid),
        .quotient      (cw_quot),
        .remainder     (cw_rem)
    );

    // free running, only the remainder of the offset matters
    div_by_const #(
        .ARG_WIDTH (CLICK_CNT_BITS),
        .DIVISOR   (DIAL_CLICKS)
    ) ccw_offset_div_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .input_valid   (1'b1),
        .argument      (dial_offset),
        .outputs_valid (),
        .quotient      (),
        .remainder     (offset_rem)
    );

    div_by_const #(
        .ARG_WIDTH (CLICK_CNT_BITS),
        .DIVISOR   (DIAL_CLICKS)
    ) ccw_cross_div_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .input_valid   (ccw_arg_valid),
        .argument      (ccw_cross_arg),
        .outputs_valid (),
        .quotient      (ccw_cross_quot),
        .remainder     ()
    );

    div_by_const #(
        .ARG_WIDTH (CLICK_CNT_BITS),
        .DIVISOR   (DIAL_CLICKS)
    ) ccw_dial_div_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .input_valid   (ccw_arg_valid),
        .argument      (ccw_dial_arg),
        .outputs_valid (ccw_div_valid),
        .quotient      (),
        .remainder     (ccw_dial_rem)
    );

    assign res_valid = cw_div_valid || ccw_div_valid;
    assign res_right = (dir_pipe[DIV_LATENCY-1] == DIR_RIGHT);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dial                 <= click_cnt_t'(DIAL_START);
            zero_crossings_valid <= 1'b0;
        end else begin
            zero_crossings_valid <= res_valid;
            if (res_valid) begin
                dial <= res_right ? cw_rem : ccw_dial_rem;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (res_valid) begin
            zero_crossings_count <= res_right ? CLICK_BITS'(cw_quot) : CLICK_BITS'(ccw_cross_quot);
        end
    end

endmodule

/* hw/line_parser.sv */
`timescale 1ns/1ps

module line_parser #(
    parameter int CLICK_BITS = 10
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  byte_valid,
    input  logic [7:0]            byte_data,
    input  logic                  input_last,
    output logic                  click_valid,
    output dial_pkg::dir_t        click_dir,
    output logic [CLICK_BITS-1:0] click_count,
    output logic                  stream_end,
    output logic                  parse_error
);
    import dial_pkg::*;

    // room for acc * 10 + 9 before the overflow check
    localparam int ACC_BITS = CLICK_BITS + 4;

    parse_state_t          state;
    dir_t                  dir;
    logic [CLICK_BITS-1:0] acc;
    logic                  have_digit;

    logic                  is_digit;
    logic                  is_newline;
    logic                  is_dir_char;
    logic [ACC_BITS-1:0]   acc_next;
    logic                  overflow;

    assign is_digit    = (byte_data >= ASCII_0) && (byte_data <= ASCII_9);
    assign is_newline  = (byte_data == ASCII_NL);
    assign is_dir_char = (byte_data == ASCII_R) || (byte_data == ASCII_L);

    // times ten as x*8 + x*2, then add the digit
    assign acc_next = (ACC_BITS'(acc) << 3) + (ACC_BITS'(acc) << 1)
                    + ACC_BITS'(byte_data - ASCII_0);
    assign overflow = |acc_next[ACC_BITS-1:CLICK_BITS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= PARSE_DIR;
            have_digit  <= 1'b0;
            click_valid <= 1'b0;
            stream_end  <= 1'b0;
            parse_error <= 1'b0;
        end else begin
            click_valid <= 1'b0;
            if (byte_valid) begin
                if (input_last) begin
                    stream_end <= 1'b1;
                end
                case (state)
                    PARSE_DIR: begin
                        if (is_dir_char) begin
                            state      <= PARSE_NUM;
                            have_digit <= 1'b0;
                        end else begin
                            // a stray newline already ends the bad line
                            parse_error <= 1'b1;
                            state       <= is_newline ? PARSE_DIR : PARSE_SKIP;
                        end
                    end
                    PARSE_NUM: begin
                        if (is_newline) begin
                            state       <= PARSE_DIR;
                            click_valid <= have_digit;
                            if (!have_digit) begin
                                parse_error <= 1'b1;
                            end
                        end else if (is_digit && !overflow) begin
                            have_digit <= 1'b1;
                        end else begin
                            parse_error <= 1'b1;
                            state       <= PARSE_SKIP;
                        end
                    end
                    PARSE_SKIP: begin
                        if (is_newline) begin
                            state <= PARSE_DIR;
                        end
                    end
                    default: begin
                        state <= PARSE_DIR;
                    end
                endcase
            end
        end
    end

    // direction and digits, held until the next line starts
    always_ff @(posedge clk) begin
        if (byte_valid) begin
            if (state == PARSE_DIR) begin
                dir <= (byte_data == ASCII_R) ? DIR_RIGHT : DIR_LEFT;
                acc <= '0;
            end else if (state == PARSE_NUM && is_digit) begin
                acc <= acc_next[CLICK_BITS-1:0];
            end
        end
    end

    assign click_dir   = dir;
    assign click_count = acc;

endmodule

/* hw/crossing_counter.sv */
`timescale 1ns/1ps

module crossing_counter #(
    parameter int TOTAL_BITS = 32,
    parameter int CLICK_BITS = 10
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  click_valid,
    input  logic                  zero_crossings_valid,
    input  logic [CLICK_BITS-1:0] zero_crossings_count,
    input  logic                  stream_end,
    output logic [TOTAL_BITS-1:0] crossing_total,
    output logic                  done
);

    // spacing keeps at most one click in the tracker, two bits is plenty
    logic [1:0] in_flight;
    logic       drained;

    // a click on this very cycle is not yet counted in in_flight
    assign drained = (in_flight == 2'd0) && !click_valid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            in_flight <= 2'd0;
        end else if (click_valid && !zero_crossings_valid) begin
            in_flight <= in_flight + 2'd1;
        end else if (zero_crossings_valid && !click_valid) begin
            in_flight <= in_flight - 2'd1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            crossing_total <= '0;
        end else if (zero_crossings_valid) begin
            crossing_total <= crossing_total + TOTAL_BITS'(zero_crossings_count);
        end
    end

    // sticky until reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done <= 1'b0;
        end else if (stream_end && drained) begin
            done <= 1'b1;
        end
    end

endmodule

/* hw/dial_top.sv */
`timescale 1ns/1ps

module dial_top #(
    parameter int CLICK_BITS  = 10,
    parameter int DIAL_CLICKS = 100,
    parameter int TOTAL_BITS  = 32
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  byte_valid,
    input  logic [7:0]            byte_data,
    input  logic                  input_last,
    output logic                  crossing_valid,
    output logic [CLICK_BITS-1:0] crossing_count,
    output logic [TOTAL_BITS-1:0] crossing_total,
    output logic                  done,
    output logic                  parse_error
);
    import dial_pkg::*;

    logic                  click_valid;
    dir_t                  click_dir;
    logic [CLICK_BITS-1:0] click_count;
    logic                  stream_end;

    line_parser #(
        .CLICK_BITS (CLICK_BITS)
    ) parser_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .byte_valid  (byte_valid),
        .byte_data   (byte_data),
        .input_last  (input_last),
        .click_valid (click_valid),
        .click_dir   (click_dir),
        .click_count (click_count),
        .stream_end  (stream_end),
        .parse_error (parse_error)
    );

    // tracker results go straight out as the per-line answer
    dial_tracker #(
        .CLICK_BITS  (CLICK_BITS),
        .DIAL_CLICKS (DIAL_CLICKS)
    ) tracker_i (
        .clk                  (clk),
        .arst_n               (arst_n),
        .click_valid          (click_valid),
        .click_dir            (click_dir),
        .click_count          (click_count),
        .zero_crossings_valid (crossing_valid),
        .zero_crossings_count (crossing_count)
    );

    crossing_counter #(
        .TOTAL_BITS (TOTAL_BITS),
        .CLICK_BITS (CLICK_BITS)
    ) counter_i (
        .clk                  (clk),
        .arst_n               (arst_n),
        .click_valid          (click_valid),
        .zero_crossings_valid (crossing_valid),
        .zero_crossings_count (crossing_count),
        .stream_end           (stream_end),
        .crossing_total       (crossing_total),
        .done                 (done)
    );

endmodule

/* tb/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD_NS = 20.0
) (
    output logic clk
);

    // free running, first rising edge after half a period
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk = ~clk;
        end
    end

endmodule

/* tb/dial_tb.sv */
`timescale 1ns/1ps

module dial_tb;
    import dial_pkg::*;

    localparam int CLICK_BITS  = 10;
    localparam int DIAL_CLICKS = 100;
    localparam int TOTAL_BITS  = 32;
    localparam int N_DIRECTED  = 7;
    localparam int N_BURST     = 8;
    localparam int N_BAD       = 4;
    localparam int N_RANDOM    = 200;

    logic                  clk;
    logic                  arst_n;
    logic                  byte_valid;
    logic [7:0]            byte_data;
    logic                  input_last;
    logic                  crossing_valid;
    logic [CLICK_BITS-1:0] crossing_count;
    logic [TOTAL_BITS-1:0] crossing_total;
    logic                  done;
    logic                  parse_error;

    // markers driven together with the bytes
    logic good_nl;
    logic bad_mark;
    logic bad_seen;
    logic end_sent;

    int                    exp_q [$];
    logic [CLICK_BITS-1:0] exp_head = '0;
    logic [TOTAL_BITS-1:0] exp_total;
    int                    model_dial;

    int error_count;
    int tests_run;
    int tests_failed;
    int cycle_count = 0;
    int cycle_limit = 1000000;

    int    dir_counts [N_DIRECTED] = '{50, 5, 5, 100, 200, 999, 1};
    bit    dir_right  [N_DIRECTED] = '{0, 0, 1, 1, 0, 1, 0};
    string bad_text   [N_BAD]      = '{"X12", "R", "R1a", "R1024"};
    int    bad_where  [N_BAD]      = '{0, 1, 2, 4};
    int    rand_counts [N_RANDOM];
    bit    rand_right  [N_RANDOM];

    tb_clock #(.PERIOD_NS(20.0)) clock_i (.clk(clk));

    dial_top #(
        .CLICK_BITS  (CLICK_BITS),
        .DIAL_CLICKS (DIAL_CLICKS),
        .TOTAL_BITS  (TOTAL_BITS)
    ) dut_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .byte_valid     (byte_valid),
        .byte_data      (byte_data),
        .input_last     (input_last),
        .crossing_valid (crossing_valid),
        .crossing_count (crossing_count),
        .crossing_total (crossing_total),
        .done           (done),
        .parse_error    (parse_error)
    );

    // applies the dial rotation rules and returns the zero crossings
    function automatic int apply_rotation(input bit right, input int n);
        int crossings;
        if (right) begin
            crossings  = (model_dial + n) / DIAL_CLICKS;
            model_dial = (model_dial + n) % DIAL_CLICKS;
        end else begin
            crossings  = (((DIAL_CLICKS - model_dial) % DIAL_CLICKS) + n) / DIAL_CLICKS;
            model_dial = ((model_dial - n) % DIAL_CLICKS + DIAL_CLICKS) % DIAL_CLICKS;
        end
        return crossings;
    endfunction

    function automatic int line_bytes(input int n);
        string digits;
        digits = $sformatf("%0d", n);
        return digits.len() + 2;
    endfunction

    // one byte every 4 cycles with a newline appended
    task automatic send_text(input string text, input int bad_pos, input bit valid_line,
                             input bit last);
        logic [7:0] b;
        for (int i = 0; i <= text.len(); i++) begin
            b = (i == text.len()) ? ASCII_NL : text[i];
            @(posedge clk);
            byte_valid <= 1'b1;
            byte_data  <= b;
            input_last <= last && (i == text.len());
            good_nl    <= valid_line && (i == text.len());
            bad_mark   <= (i == bad_pos);
            if (i == bad_pos) begin
                bad_seen <= 1'b1;
            end
            if (last && i == text.len()) begin
                end_sent <= 1'b1;
            end
            @(posedge clk);
            byte_valid <= 1'b0;
            input_last <= 1'b0;
            good_nl    <= 1'b0;
            bad_mark   <= 1'b0;
            repeat (2) @(posedge clk);
        end
    endtask

    task automatic send_rotation(input bit right, input int n, input bit last);
        int crossings;
        crossings = apply_rotation(right, n);
        exp_q.push_back(crossings);
        exp_total = exp_total + TOTAL_BITS'(crossings);
        send_text($sformatf("%s%0d", right ? "R" : "L", n), -1, 1'b1, last);
    endtask

    task automatic wait_results();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        @(posedge clk);
        assert (dut_i.parser_i.state == PARSE_DIR)
            else begin
                $display("parser did not return to the line start state");
                error_count++;
            end
    endtask

    // dial, total and sticky error all start over
    task automatic apply_reset();
        @(posedge clk);
        arst_n   <= 1'b0;
        bad_seen <= 1'b0;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        model_dial = DIAL_START;
        exp_total  = '0;
        repeat (2) @(posedge clk);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (error_count != errs_before) begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", tests_run, name,
                     error_count - errs_before);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
    endtask

    // expected head follows the results as they come out
    always @(posedge clk) begin
        if (arst_n && crossing_valid && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
        end
        if (exp_q.size() > 0) begin
            exp_head <= CLICK_BITS'(exp_q[0]);
        end else begin
            exp_head <= '0;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run still busy after %0d cycles", cycle_count);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    a_reset: assert property (@(posedge clk)
        $rose(arst_n) |-> !crossing_valid && !done && !parse_error && crossing_total == '0)
        else begin
            $display("outputs not at their reset values after reset");
            error_count++;
        end

    a_count: assert property (@(posedge clk) disable iff (!arst_n)
        crossing_valid |-> crossing_count == exp_head)
        else begin
            $display("mismatch crossing_count: got 0x%h, expected 0x%h",
                     $sampled(crossing_count), $sampled(exp_head));
            error_count++;
        end

    // newline to result is exactly 6 cycles
    a_timing: assert property (@(posedge clk) disable iff (!arst_n)
        $past(good_nl, 6) |-> crossing_valid)
        else begin
            $display("crossing_valid missing 6 cycles after a valid line");
            error_count++;
        end

    a_spurious: assert property (@(posedge clk) disable iff (!arst_n)
        crossing_valid |-> $past(good_nl, 6))
        else begin
            $display("crossing_valid without a valid line 6 cycles before");
            error_count++;
        end

    a_err_set: assert property (@(posedge clk) disable iff (!arst_n)
        $past(bad_mark) |-> parse_error)
        else begin
            $display("parse_error not set after a malformed byte");
            error_count++;
        end

    a_err_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        !bad_seen |-> !parse_error)
        else begin
            $display("parse_error set before any malformed line");
            error_count++;
        end

    a_total: assert property (@(posedge clk) disable iff (!arst_n)
        done |-> crossing_total == exp_total)
        else begin
            $display("mismatch crossing_total: got 0x%h, expected 0x%h",
                     $sampled(crossing_total), $sampled(exp_total));
            error_count++;
        end

    a_done_early: assert property (@(posedge clk) disable iff (!arst_n)
        done |-> end_sent)
        else begin
            $display("done high before the stream ended");
            error_count++;
        end

    initial begin
        int total_bytes;
        int errs;
        arst_n       = 1'b0;
        byte_valid   = 1'b0;
        byte_data    = 8'h00;
        input_last   = 1'b0;
        good_nl      = 1'b0;
        bad_mark     = 1'b0;
        bad_seen     = 1'b0;
        end_sent     = 1'b0;
        exp_total    = '0;
        model_dial   = DIAL_START;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(32'ha4b97b4c));

        // run length sets the watchdog limit
        total_bytes = 0;
        for (int i = 0; i < N_DIRECTED; i++) begin
            total_bytes += line_bytes(dir_counts[i]);
        end
        for (int i = 0; i < N_BURST; i++) begin
            total_bytes += line_bytes(i * 7);
        end
        for (int i = 0; i < N_BAD; i++) begin
            total_bytes += bad_text[i].len() + 1;
        end
        total_bytes += N_BAD * line_bytes(7) + line_bytes(93);
        for (int i = 0; i < N_RANDOM; i++) begin
            rand_counts[i] = $urandom % 1000;
            rand_right[i]  = ($urandom % 2) == 1;
            total_bytes += line_bytes(rand_counts[i]);
        end
        cycle_limit = 2 * total_bytes * 4 + 200;

        errs = error_count;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        repeat (2) @(posedge clk);
        finish_test("reset values", errs);

        errs = error_count;
        for (int i = 0; i < N_DIRECTED; i++) begin
            send_rotation(dir_right[i], dir_counts[i], 1'b0);
        end
        wait_results();
        finish_test("directed rotations", errs);

        // lines at the minimum spacing
        errs = error_count;
        for (int i = 0; i < N_BURST; i++) begin
            send_rotation(i % 2 == 1, i * 7, 1'b0);
        end
        wait_results();
        finish_test("back to back lines", errs);

        // each malformed line meets a parse_error that is still low
        errs = error_count;
        for (int i = 0; i < N_BAD; i++) begin
            apply_reset();
            send_text(bad_text[i], bad_where[i], 1'b0, 1'b0);
            send_rotation(1'b0, 7, 1'b0);
            wait_results();
        end
        send_rotation(1'b1, 93, 1'b0);
        wait_results();
        finish_test("malformed lines", errs);

        errs = error_count;
        for (int i = 0; i < N_RANDOM; i++) begin
            send_rotation(rand_right[i], rand_counts[i], i == N_RANDOM - 1);
        end
        while (!done) begin
            @(posedge clk);
        end
        wait_results();
        @(posedge clk);
        finish_test("random rotations", errs);

        $display("tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* all.f */
common/dial_pkg.sv
dial/div_by_const.sv
dial/dial_tracker.sv
hw/line_parser.sv
hw/crossing_counter.sv
hw/dial_top.sv
tb/tb_clock.sv
tb/dial_tb.sv

/* run.sh */
#!/bin/sh
# build and run the dial testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module dial_tb \
    -f all.f -o dial_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/dial_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" "$LOG"; then
    echo "no result line found in $LOG"
    exit 1
fi
exit 0
